// File: Makefile
# Verilator simulation of the scan doubler video path

VERILATOR ?= verilator
TOP       ?= tb_scan2x_video
FILELIST  ?= scan2x_video.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

# Build, run, and fail unless the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: hw/scan2x_line_buffer.sv
/* Two-bank line memory for the scan doubler
   One bank fills at pixel rate while the other is replayed */
`timescale 1ns/1ps
`include "video_defines.svh"

module scan2x_line_buffer (
    input  logic                    clk_sys,
    input  logic                    arst_n,
    input  video_pkg::pix_wide_t    pix,
    input  logic [`VIDEO_ADDRW-1:0] rd_addr,
    output video_pkg::rgb_wide_t    rd_pix,
    output logic [`VIDEO_ADDRW:0]   line_len,
    output logic                    line_start
);

    localparam int CW = `VIDEO_ADDRW + 1;

    // Bank select is the top address bit
    video_pkg::rgb_wide_t mem [0:2*`VIDEO_HLEN-1];

    logic          wr_bank;
    logic [CW-1:0] wr_cnt;
    logic          hs_last;
    logic          armed;
    logic          hs_rise;
    logic          wr_full;
    logic          wr_en;

    assign hs_rise = pix.valid & pix.hs & ~hs_last;
    assign wr_full = (wr_cnt == CW'(`VIDEO_HLEN));

    // Nothing is stored until the first HS, so a partial line never shows
    assign wr_en = pix.valid & pix.lhbl & armed & ~hs_rise & ~wr_full;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            wr_bank    <= 1'b0;
            wr_cnt     <= '0;
            hs_last    <= 1'b0;
            armed      <= 1'b0;
            line_len   <= '0;
            line_start <= 1'b0;
        end else begin
            line_start <= hs_rise;
            if (pix.valid) begin
                hs_last <= pix.hs;
            end
            if (hs_rise) begin
                // Finished line becomes the read bank
                armed    <= 1'b1;
                wr_bank  <= ~wr_bank;
                wr_cnt   <= '0;
                line_len <= wr_cnt;
            end else if (wr_en) begin
                wr_cnt <= wr_cnt + CW'(1);
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[{wr_bank, wr_cnt[`VIDEO_ADDRW-1:0]}] <= pix.rgb;
        end
        rd_pix <= mem[{~wr_bank, rd_addr}];
    end

endmodule

// File: hw/scan2x_reader.sv
/* Scan doubler read side
   Replays each stored line twice with blending, scanline dimming and 8-bit extension */
`timescale 1ns/1ps
`include "video_defines.svh"

module scan2x_reader (
    input  logic                    clk_sys,
    input  logic                    arst_n,
    input  logic                    pxl2_cen,
    input  logic                    blend_en,
    input  video_pkg::sl_mode_t     sl_mode,
    input  logic                    line_start,
    input  logic [`VIDEO_ADDRW:0]   line_len,
    output logic [`VIDEO_ADDRW-1:0] rd_addr,
    input  video_pkg::rgb_wide_t    rd_pix,
    output video_pkg::rgb_out_t     rgb_out,
    output logic                    out_hs,
    output logic                    out_de,
    output logic                    out_cen
);

    localparam int CW = `VIDEO_ADDRW + 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HS,
        ST_PIX
    } state_t;

    state_t        state;
    logic          pass;
    logic [CW-1:0] cnt;
    logic [CW-1:0] last_idx;

    // Flags sampled at a strobe line up with the read data one clock later
    logic s1_stb;
    logic s1_busy;
    logic s1_hs;
    logic s1_de;
    logic s1_first;
    logic s1_dim;

    video_pkg::rgb_wide_t prev_pix;
    video_pkg::rgb_out_t  shaded;
    logic                 blend_now;

    // Blend, then dim, then extend one channel
    function automatic logic [`VIDEO_OUTW-1:0] shade_chan(
        input logic [`VIDEO_CLROUTW-1:0] cur,
        input logic [`VIDEO_CLROUTW-1:0] last,
        input logic                      blend,
        input logic                      dim,
        input video_pkg::sl_mode_t       mode
    );
        logic [`VIDEO_CLROUTW:0]   sum;
        logic [`VIDEO_CLROUTW-1:0] v;
        sum = {1'b0, cur} + {1'b0, last};
        v   = blend ? sum[`VIDEO_CLROUTW:1] : cur;
        if (dim) begin
            case (mode)
                video_pkg::SL_25: v = v - (v >> 2);
                video_pkg::SL_50: v = v >> 1;
                video_pkg::SL_75: v = v >> 2;
                default:          v = v;
            endcase
        end
        return {v, v[`VIDEO_CLROUTW-1 -: `VIDEO_EXTW]};
    endfunction

    assign last_idx = line_len - CW'(1);
    assign rd_addr  = cnt[`VIDEO_ADDRW-1:0];

    // HS pulse, pixels, then the same again for the second pass
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            pass  <= 1'b0;
            cnt   <= '0;
        end else if (line_start) begin
            state <= (line_len == '0) ? ST_IDLE : ST_HS;
            pass  <= 1'b0;
            cnt   <= '0;
        end else if (pxl2_cen) begin
            case (state)
                ST_HS: begin
                    if (cnt == CW'(`VIDEO_HS_LEN - 1)) begin
                        state <= ST_PIX;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + CW'(1);
                    end
                end
                ST_PIX: begin
                    if (cnt == last_idx) begin
                        cnt <= '0;
                        if (pass) begin
                            state <= ST_IDLE;
                        end else begin
                            pass  <= 1'b1;
                            state <= ST_HS;
                        end
                    end else begin
                        cnt <= cnt + CW'(1);
                    end
                end
                default: cnt <= '0;
            endcase
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            s1_stb   <= 1'b0;
            s1_busy  <= 1'b0;
            s1_hs    <= 1'b0;
            s1_de    <= 1'b0;
            s1_first <= 1'b0;
            s1_dim   <= 1'b0;
        end else begin
            s1_stb <= pxl2_cen;
            if (pxl2_cen) begin
                s1_busy  <= (state != ST_IDLE);
                s1_hs    <= (state == ST_HS);
                s1_de    <= (state == ST_PIX);
                s1_first <= (cnt == '0);
                s1_dim   <= pass;
            end
        end
    end

    // First pixel of a pass has no left neighbour
    always_comb begin
        blend_now = blend_en & ~s1_first;
        shaded.r  = shade_chan(rd_pix.r, prev_pix.r, blend_now, s1_dim, sl_mode);
        shaded.g  = shade_chan(rd_pix.g, prev_pix.g, blend_now, s1_dim, sl_mode);
        shaded.b  = shade_chan(rd_pix.b, prev_pix.b, blend_now, s1_dim, sl_mode);
    end

    // Output sync two clocks after the strobe
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            out_cen <= 1'b0;
            out_hs  <= 1'b0;
            out_de  <= 1'b0;
        end else begin
            out_cen <= s1_stb & s1_busy;
            if (s1_stb) begin
                out_hs <= s1_hs;
                out_de <= s1_de;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (s1_stb && s1_de) begin
            rgb_out  <= shaded;
            prev_pix <= rd_pix;
        end
    end

endmodule

// File: hw/scan2x_video_top.sv
/* Video path top level
   Bandwidth filter, line buffer and scan doubler reader */
`timescale 1ns/1ps
`include "video_defines.svh"

module scan2x_video_top (
    input  logic                 clk_sys,
    input  logic                 arst_n,
    input  logic                 pxl_cen,
    input  logic                 pxl2_cen,
    input  video_pkg::video_in_t video_in,
    input  logic                 bw_en,
    input  logic                 blend_en,
    input  video_pkg::sl_mode_t  sl_mode,
    output video_pkg::rgb_out_t  rgb_out,
    output logic                 out_hs,
    output logic                 out_de,
    output logic                 out_cen
);

    video_pkg::pix_wide_t    pix;
    video_pkg::rgb_wide_t    rd_pix;
    logic [`VIDEO_ADDRW-1:0] rd_addr;
    logic [`VIDEO_ADDRW:0]   line_len;
    logic                    line_start;

    video_bw_filter u_filter (
        .clk_sys    ( clk_sys    ),
        .arst_n     ( arst_n     ),
        .pxl_cen    ( pxl_cen    ),
        .bw_en      ( bw_en      ),
        .video_in   ( video_in   ),
        .pix        ( pix        )
    );

    scan2x_line_buffer u_buffer (
        .clk_sys    ( clk_sys    ),
        .arst_n     ( arst_n     ),
        .pix        ( pix        ),
        .rd_addr    ( rd_addr    ),
        .rd_pix     ( rd_pix     ),
        .line_len   ( line_len   ),
        .line_start ( line_start )
    );

    scan2x_reader u_reader (
        .clk_sys    ( clk_sys    ),
        .arst_n     ( arst_n     ),
        .pxl2_cen   ( pxl2_cen   ),
        .blend_en   ( blend_en   ),
        .sl_mode    ( sl_mode    ),
        .line_start ( line_start ),
        .line_len   ( line_len   ),
        .rd_addr    ( rd_addr    ),
        .rd_pix     ( rd_pix     ),
        .rgb_out    ( rgb_out    ),
        .out_hs     ( out_hs     ),
        .out_de     ( out_de     ),
        .out_cen    ( out_cen    )
    );

endmodule

// File: hw/video_bw_filter.sv
/* Colour bandwidth filter
   Widens each channel by one bit, optionally adding the previous pixel */
`timescale 1ns/1ps
`include "video_defines.svh"

module video_bw_filter (
    input  logic                 clk_sys,
    input  logic                 arst_n,
    input  logic                 pxl_cen,
    input  logic                 bw_en,
    input  video_pkg::video_in_t video_in,
    output video_pkg::pix_wide_t pix
);

    video_pkg::rgb_in_t   prev_rgb;
    video_pkg::rgb_wide_t rgb_q;
    logic                 valid_q;
    logic                 hs_q;
    logic                 lhbl_q;

    // Low pass as a sum of neighbours, or a plain shift when disabled
    function automatic logic [`VIDEO_CLROUTW-1:0] bw_chan(
        input logic [`VIDEO_COLORW-1:0] cur,
        input logic [`VIDEO_COLORW-1:0] last,
        input logic                     en
    );
        logic [`VIDEO_CLROUTW-1:0] sum;
        sum = {1'b0, cur} + {1'b0, last};
        return en ? sum : {cur, 1'b0};
    endfunction

    // Strobe and sync follow the input by one clock
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            hs_q    <= 1'b0;
            lhbl_q  <= 1'b0;
        end else begin
            valid_q <= pxl_cen;
            if (pxl_cen) begin
                hs_q   <= video_in.hs;
                lhbl_q <= video_in.lhbl;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            rgb_q.r <= bw_chan(video_in.rgb.r, prev_rgb.r, bw_en);
            rgb_q.g <= bw_chan(video_in.rgb.g, prev_rgb.g, bw_en);
            rgb_q.b <= bw_chan(video_in.rgb.b, prev_rgb.b, bw_en);
            // Blanking zeroes the history so each line starts clean
            prev_rgb <= video_in.lhbl ? video_in.rgb : '0;
        end
    end

    always_comb begin
        pix.valid = valid_q;
        pix.rgb   = rgb_q;
        pix.hs    = hs_q;
        pix.lhbl  = lhbl_q;
    end

endmodule

// File: hw/video_defines.svh
/* Colour widths, line buffer geometry and output HS pulse length
   for the scan doubler video path */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Colour width per channel at the input
`define VIDEO_COLORW   4
// One bit wider after the bandwidth filter
`define VIDEO_CLROUTW  (`VIDEO_COLORW + 1)
// Output colour width per channel
`define VIDEO_OUTW     8
// Bits replicated below each channel when extending to the output width
`define VIDEO_EXTW     (`VIDEO_OUTW - `VIDEO_CLROUTW)

// Active pixels per line and the depth of one buffer bank
`define VIDEO_HLEN     64
`define VIDEO_ADDRW    6

// Output HS pulse length in pxl2_cen strobes
`define VIDEO_HS_LEN   4

`endif

// File: hw/video_pkg.sv
/* Pixel, sync and scanline types shared by the video path */
`include "video_defines.svh"

package video_pkg;

    // Raw game colour
    typedef struct packed {
        logic [`VIDEO_COLORW-1:0] r;
        logic [`VIDEO_COLORW-1:0] g;
        logic [`VIDEO_COLORW-1:0] b;
    } rgb_in_t;

    // Filtered colour stored in the line buffer
    typedef struct packed {
        logic [`VIDEO_CLROUTW-1:0] r;
        logic [`VIDEO_CLROUTW-1:0] g;
        logic [`VIDEO_CLROUTW-1:0] b;
    } rgb_wide_t;

    typedef struct packed {
        logic [`VIDEO_OUTW-1:0] r;
        logic [`VIDEO_OUTW-1:0] g;
        logic [`VIDEO_OUTW-1:0] b;
    } rgb_out_t;

    // lhbl is low during horizontal blanking
    typedef struct packed {
        rgb_in_t rgb;
        logic    hs;
        logic    lhbl;
    } video_in_t;

    typedef struct packed {
        logic      valid;
        rgb_wide_t rgb;
        logic      hs;
        logic      lhbl;
    } pix_wide_t;

    typedef enum logic [1:0] {
        SL_OFF,
        SL_25,
        SL_50,
        SL_75
    } sl_mode_t;

endpackage

// File: scan2x_video.f
+incdir+hw
hw/video_pkg.sv
hw/video_bw_filter.sv
hw/scan2x_line_buffer.sv
hw/scan2x_reader.sv
hw/scan2x_video_top.sv
sim/tb_scan2x_video.sv

// File: sim/tb_scan2x_video.sv
/* Testbench for the scan doubler video path
   Random lines, a reference model of the output and checking assertions */
`timescale 1ns/1ps
`include "video_defines.svh"

module tb_scan2x_video;

    localparam int ACTIVE   = 32;
    localparam int BLANK    = 16;
    localparam int HS_AT    = 4;
    localparam int N_LINES  = 10;
    localparam int RST_CYC  = 5;
    localparam int IW       = `VIDEO_COLORW;
    localparam int CW       = `VIDEO_CLROUTW;
    localparam int OUTW     = `VIDEO_OUTW;
    // Four clocks per pixel period plus one spare line for the drain
    localparam int STIM_CYC = RST_CYC + (N_LINES + 1) * (ACTIVE + BLANK) * 4;
    localparam int TIMEOUT  = 2 * STIM_CYC;

    logic                 clk_sys = 1'b0;
    logic                 arst_n;
    logic                 pxl_cen;
    logic                 pxl2_cen;
    video_pkg::video_in_t video_in;
    logic                 bw_en;
    logic                 blend_en;
    video_pkg::sl_mode_t  sl_mode;
    video_pkg::rgb_out_t  rgb_out;
    logic                 out_hs;
    logic                 out_de;
    logic                 out_cen;

    // Expected output pixels in order, and the widened line being sent
    video_pkg::rgb_out_t  exp_q[$];
    video_pkg::rgb_wide_t line_mem [ACTIVE];

    int errors      = 0;
    int pix_checked = 0;
    int hs_checked  = 0;
    int hs_driven   = 0;
    int hs_run      = 0;
    int de_run      = 0;
    int cycles      = 0;

    scan2x_video_top u_dut (
        .clk_sys  ( clk_sys  ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .pxl2_cen ( pxl2_cen ),
        .video_in ( video_in ),
        .bw_en    ( bw_en    ),
        .blend_en ( blend_en ),
        .sl_mode  ( sl_mode  ),
        .rgb_out  ( rgb_out  ),
        .out_hs   ( out_hs   ),
        .out_de   ( out_de   ),
        .out_cen  ( out_cen  )
    );

    always #10 clk_sys = ~clk_sys;

    // Sum with the left neighbour, or a plain doubling
    function automatic logic [CW-1:0] widen(
        input logic [IW-1:0] cur,
        input logic [IW-1:0] left,
        input logic          en
    );
        return en ? CW'(int'(cur) + int'(left)) : CW'(int'(cur) * 2);
    endfunction

    // Average, darken on the repeated pass, then fill the low bits from the top
    function automatic logic [OUTW-1:0] expect_chan(
        input logic [CW-1:0]       cur,
        input logic [CW-1:0]       left,
        input logic                blend,
        input logic                dim,
        input video_pkg::sl_mode_t mode
    );
        int v;
        v = blend ? (int'(cur) + int'(left)) / 2 : int'(cur);
        if (dim) begin
            case (mode)
                video_pkg::SL_25: v = v - v / 4;
                video_pkg::SL_50: v = v / 2;
                video_pkg::SL_75: v = v / 4;
                default:          v = v;
            endcase
        end
        return OUTW'((v << (OUTW - CW)) | (v >> (2 * CW - OUTW)));
    endfunction

    // Test sections by line number; line 0 is never shown
    task automatic select_mode(input int line, output logic bw, output logic blend,
                               output video_pkg::sl_mode_t sl);
        bw    = (line == 3 || line == 4 || line >= 8);
        blend = (line >= 8);
        case (line)
            5:       sl = video_pkg::SL_25;
            6, 8, 9: sl = video_pkg::SL_50;
            7:       sl = video_pkg::SL_75;
            default: sl = video_pkg::SL_OFF;
        endcase
    endtask

    task automatic push_expected(input logic blend, input video_pkg::sl_mode_t sl);
        video_pkg::rgb_out_t  e;
        video_pkg::rgb_wide_t left;
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < ACTIVE; i++) begin
                left = (i == 0) ? line_mem[0] : line_mem[i-1];
                e.r  = expect_chan(line_mem[i].r, left.r, blend && i > 0, pass == 1, sl);
                e.g  = expect_chan(line_mem[i].g, left.g, blend && i > 0, pass == 1, sl);
                e.b  = expect_chan(line_mem[i].b, left.b, blend && i > 0, pass == 1, sl);
                exp_q.push_back(e);
            end
        end
    endtask

    // One pixel period with pxl_cen on the first of two pxl2_cen
    task automatic drive_pixel(input video_pkg::video_in_t v);
        @(posedge clk_sys);
        pxl_cen  <= 1'b1;
        pxl2_cen <= 1'b1;
        video_in <= v;
        @(posedge clk_sys);
        pxl_cen  <= 1'b0;
        pxl2_cen <= 1'b0;
        @(posedge clk_sys);
        pxl2_cen <= 1'b1;
        @(posedge clk_sys);
        pxl2_cen <= 1'b0;
    endtask

    task automatic run_line(input int line);
        video_pkg::video_in_t v;
        video_pkg::rgb_in_t   left;
        logic                 bw;
        logic                 blend;
        video_pkg::sl_mode_t  sl;
        select_mode(line, bw, blend, sl);
        bw_en <= bw;
        left = '0;
        for (int i = 0; i < ACTIVE; i++) begin
            v            = '0;
            v.rgb.r      = IW'($urandom());
            v.rgb.g      = IW'($urandom());
            v.rgb.b      = IW'($urandom());
            v.lhbl       = 1'b1;
            line_mem[i].r = widen(v.rgb.r, left.r, bw);
            line_mem[i].g = widen(v.rgb.g, left.g, bw);
            line_mem[i].b = widen(v.rgb.b, left.b, bw);
            left         = v.rgb;
            drive_pixel(v);
        end
        for (int i = 0; i < BLANK; i++) begin
            v    = '0;
            v.hs = (i >= HS_AT && i < HS_AT + 4);
            // Previous line has finished its replay by now
            if (i == 0) begin
                blend_en <= blend;
                sl_mode  <= sl;
            end
            if (i == HS_AT) begin
                hs_driven <= hs_driven + 1;
                if (line > 0) begin
                    push_expected(blend, sl);
                end
            end
            drive_pixel(v);
        end
    endtask

    always @(posedge clk_sys) begin : check_outputs
        video_pkg::rgb_out_t want;
        if (hs_driven < 2) begin
            assert (!out_de && !out_hs && !out_cen) else begin
                errors++;
                $display("[FAIL] %0t: output active before the second input HS", $time);
            end
        end
        if (out_cen) begin
            assert (!(out_hs && out_de)) else begin
                errors++;
                $display("[FAIL] %0t: out_hs and out_de high together", $time);
            end
            if (out_hs) begin
                if (de_run != 0) begin
                    assert (de_run == ACTIVE) else begin
                        errors++;
                        $display("[FAIL] %0t: pass length expected %0d got %0d",
                                 $time, ACTIVE, de_run);
                    end
                end
                de_run = 0;
                hs_run++;
            end
            if (out_de) begin
                if (hs_run != 0) begin
                    assert (hs_run == `VIDEO_HS_LEN) else begin
                        errors++;
                        $display("[FAIL] %0t: HS length expected %0d got %0d",
                                 $time, `VIDEO_HS_LEN, hs_run);
                    end
                    hs_checked++;
                end
                hs_run = 0;
                de_run++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output pixel at %0t when no pixel was expected", $time);
                end else begin
                    want = exp_q.pop_front();
                    assert (rgb_out == want) else begin
                        errors++;
                        $display("[FAIL] %0t: pixel %0d expected %h got %h",
                                 $time, pix_checked, want, rgb_out);
                    end
                    pix_checked++;
                end
            end
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Run timed out after %0d cycles with %0d pixels still expected",
                     cycles, exp_q.size());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        void'($urandom(3167));
        arst_n   = 1'b0;
        pxl_cen  = 1'b0;
        pxl2_cen = 1'b0;
        video_in = '0;
        bw_en    = 1'b0;
        blend_en = 1'b0;
        sl_mode  = video_pkg::SL_OFF;
        repeat (RST_CYC) @(posedge clk_sys);
        arst_n <= 1'b1;
        for (int k = 0; k < N_LINES; k++) begin
            run_line(k);
        end
        // Blank periods until the last line has been replayed
        while (exp_q.size() != 0) begin
            drive_pixel('0);
        end
        // Every shown pass has its own HS pulse, and the last pass is complete
        assert (hs_checked == 2 * (N_LINES - 1)) else begin
            errors++;
            $display("[FAIL] %0t: HS pulses expected %0d got %0d",
                     $time, 2 * (N_LINES - 1), hs_checked);
        end
        assert (de_run == ACTIVE) else begin
            errors++;
            $display("[FAIL] %0t: last pass length expected %0d got %0d",
                     $time, ACTIVE, de_run);
        end
        $display("Checked %0d pixels and %0d HS pulses, %0d errors",
                 pix_checked, hs_checked, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
